//--- bench/clct_trace.txt
# hit words for layers 0..5 (28 bit hex), busy mask (7 bit hex)
# expected found, all_busy, key, pid, nhits (hex)
0000000 0000000 0000000 0000000 0000000 0000000 00 0 0 00 4 0
0002000 0002000 0002000 0002000 0002000 0002000 00 1 0 0d 4 6
0000001 0000001 0000001 0000001 0000001 0000001 00 1 0 00 4 6
8000000 8000000 8000000 8000000 8000000 8000000 00 1 0 1b 4 6
# bent tracks, wide and moderate, left and right
0000100 0000200 0000400 0000400 0000800 0001000 00 1 0 0a 0 6
0001000 0000800 0000400 0000400 0000200 0000100 00 1 0 0a 1 6
0080000 0080000 0100000 0100000 0200000 0200000 00 1 0 14 2 6
0200000 0200000 0100000 0100000 0080000 0080000 00 1 0 14 3 6
0000008 0400010 0400020 0400020 0400040 0400080 00 1 0 05 0 6
2000040 2000040 2000040 2000040 2000040 2000040 00 1 0 06 4 6
0000a00 0000a00 0000a00 0000a00 0000a00 0000a00 00 1 0 09 4 6
0002004 0002004 0002004 0002004 0002004 0002000 08 1 0 02 4 5
2000040 2000040 2000040 2000040 2000040 2000040 02 1 0 19 4 6
0002000 0002000 0002000 0002000 0002000 0002000 7f 0 1 00 0 0
0000000 0000000 0000000 0000000 0000000 0000000 7f 0 1 00 0 0
0020000 0000000 0020000 0000000 0020000 0000000 00 0 0 11 4 3
0020000 0020000 0020000 0020000 0000000 0000000 00 1 0 11 4 4
4000000 0000000 1000000 0000000 0800000 0000000 00 0 0 18 1 3
# burst of straight tracks to fill the result queue
0000002 0000002 0000002 0000002 0000002 0000002 00 1 0 01 4 6
0000010 0000010 0000010 0000010 0000010 0000010 00 1 0 04 4 6
0000080 0000080 0000080 0000080 0000080 0000080 00 1 0 07 4 6
0000100 0000100 0000100 0000100 0000100 0000100 00 1 0 08 4 6
0001000 0001000 0001000 0001000 0001000 0001000 00 1 0 0c 4 6
0008000 0008000 0008000 0008000 0008000 0008000 00 1 0 0f 4 6
0010000 0010000 0010000 0010000 0010000 0010000 00 1 0 10 4 6
0040000 0040000 0040000 0040000 0040000 0040000 00 1 0 12 4 6
0200000 0200000 0200000 0200000 0200000 0200000 00 1 0 15 4 6
0800000 0800000 0800000 0800000 0800000 0800000 00 1 0 17 4 6
4000000 4000000 4000000 4000000 4000000 4000000 00 1 0 1a 4 6
0000008 0000008 0000008 0000008 0000008 0000008 00 1 0 03 4 6

//--- bench/tb_clct_pattern_finder.sv
`timescale 1ns/1ns

module tb_clct_pattern_finder;
  import clct_pkg::*;

  localparam int KEYS_PER_GROUP = 4;
  localparam int HIT_THRESH     = 4;
  localparam int QUEUE_DEPTH    = 4;
  localparam int NKEYS          = NGROUPS * KEYS_PER_GROUP;
  localparam int KEY_W          = GRP_W + lkey_w(KEYS_PER_GROUP);
  localparam int RESET_CYCLES   = 16;

  logic                          clock;
  logic                          rst_n;
  logic                          in_req;
  logic                          in_ack;
  logic [NLAYERS-1:0][NKEYS-1:0] in_hits;
  logic [NGROUPS-1:0]            in_busy;
  logic                          out_req;
  logic                          out_ack;
  logic [KEY_W-1:0]              out_key;
  logic [PID_W-1:0]              out_pid;
  logic [NHIT_W-1:0]             out_nhits;
  logic                          out_found;
  logic                          out_all_busy;

  // frames and expected results, one entry per trace line
  logic [NLAYERS-1:0][NKEYS-1:0] tr_hits [$];
  logic [NGROUPS-1:0]            tr_busy [$];
  logic                          tr_found [$];
  logic                          tr_all_busy [$];
  logic [KEY_W-1:0]              tr_key [$];
  logic [PID_W-1:0]              tr_pid [$];
  logic [NHIT_W-1:0]             tr_nhits [$];
  int                            nframes;
  bit                            trace_loaded = 1'b0;

  int          value_errors;
  int          other_errors;
  int          stalled_frames;
  logic [31:0] lfsr_state;
  // handshake monitor state
  int          cycle = 0;
  int          captured = 0;
  int          popped = 0;
  int          first_cap_cycle = -1;
  int          first_out_cycle = -1;
  logic        ack_prev = 1'b0;
  logic        req_prev = 1'b0;

  clct_pattern_finder #(
    .KEYS_PER_GROUP (KEYS_PER_GROUP),
    .HIT_THRESH     (HIT_THRESH),
    .QUEUE_DEPTH    (QUEUE_DEPTH)
  ) clct_pattern_finder_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .in_hits      (in_hits),
    .in_busy      (in_busy),
    .out_req      (out_req),
    .out_ack      (out_ack),
    .out_key      (out_key),
    .out_pid      (out_pid),
    .out_nhits    (out_nhits),
    .out_found    (out_found),
    .out_all_busy (out_all_busy)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERR %s: got %h expected %h", name, got, expected);
      value_errors++;
    end
  endtask

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic load_trace();
    int                            fd;
    int                            n;
    string                         line;
    logic [31:0]                   w0, w1, w2, w3, w4, w5;
    logic [31:0]                   bz, ef, eab, ek, ep, en;
    logic [NLAYERS-1:0][NKEYS-1:0] hw;
    fd = $fopen("bench/clct_trace.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the trace file bench/clct_trace.txt");
      other_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        // skip comments and blank lines
        if (n > 0 && line.len() > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      w0, w1, w2, w3, w4, w5, bz, ef, eab, ek, ep, en);
          if (n != 12)
          begin
            $display("trace line could not be parsed: %s", line);
            other_errors++;
          end
          else
          begin
            hw = {w5[NKEYS-1:0], w4[NKEYS-1:0], w3[NKEYS-1:0],
                  w2[NKEYS-1:0], w1[NKEYS-1:0], w0[NKEYS-1:0]};
            tr_hits.push_back(hw);
            tr_busy.push_back(bz[NGROUPS-1:0]);
            tr_found.push_back(ef[0]);
            tr_all_busy.push_back(eab[0]);
            tr_key.push_back(ek[KEY_W-1:0]);
            tr_pid.push_back(ep[PID_W-1:0]);
            tr_nhits.push_back(en[NHIT_W-1:0]);
          end
        end
      end
      $fclose(fd);
    end
    nframes = tr_hits.size();
  endtask

  // ----------------------------------------------------------
  // input side, four-phase source
  // ----------------------------------------------------------
  task automatic send_frames();
    int waits;
    for (int i = 0; i < nframes; i++)
    begin
      @(posedge clock);
      in_hits <= tr_hits[i];
      in_busy <= tr_busy[i];
      in_req  <= 1'b1;
      waits = 1;
      @(posedge clock);
      while (!in_ack)
      begin
        @(posedge clock);
        waits++;
      end
      // two edges is an ack without back-pressure
      if (waits > 2)
        stalled_frames++;
      in_req <= 1'b0;
      @(posedge clock);
      while (in_ack)
        @(posedge clock);
    end
  endtask

  // ----------------------------------------------------------
  // output side, sink with random ack delay
  // ----------------------------------------------------------
  task automatic collect_results();
    int delay;
    for (int i = 0; i < nframes; i++)
    begin
      @(posedge clock);
      while (!out_req)
        @(posedge clock);
      // results come back in trace order
      check_value($sformatf("out_found[%0d]", i), out_found, tr_found[i]);
      check_value($sformatf("out_all_busy[%0d]", i), out_all_busy, tr_all_busy[i]);
      check_value($sformatf("out_key[%0d]", i), out_key, tr_key[i]);
      check_value($sformatf("out_pid[%0d]", i), out_pid, tr_pid[i]);
      check_value($sformatf("out_nhits[%0d]", i), out_nhits, tr_nhits[i]);
      draw_bits(5, delay);
      repeat (delay) @(posedge clock);
      out_ack <= 1'b1;
      @(posedge clock);
      while (out_req)
        @(posedge clock);
      out_ack <= 1'b0;
    end
  endtask

  // capture and pop counting, values taken before the edge updates them
  always @(posedge clock)
  begin
    cycle++;
    if (in_ack === 1'b1 && ack_prev !== 1'b1)
    begin
      captured++;
      if (first_cap_cycle < 0)
        first_cap_cycle = cycle;
      // frames in flight can never exceed the queue slots
      if (captured - popped > QUEUE_DEPTH)
      begin
        $display("in_ack rose with %0d frames outstanding and no free slot",
                 captured - popped);
        other_errors++;
      end
    end
    if (out_req === 1'b1 && req_prev !== 1'b1 && first_out_cycle < 0)
      first_out_cycle = cycle;
    if (out_req === 1'b1 && out_ack === 1'b1)
      popped++;
    ack_prev = in_ack;
    req_prev = out_req;
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial
  begin
    in_req         = 1'b0;
    in_hits        = '0;
    in_busy        = '0;
    out_ack        = 1'b0;
    rst_n          = 1'b0;
    value_errors   = 0;
    other_errors   = 0;
    stalled_frames = 0;
    lfsr_state     = 32'heaad_e27a;
    load_trace();
    if (nframes == 0)
    begin
      $display("no frames were loaded from the trace");
      other_errors++;
    end
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    check_value("in_ack", in_ack, 32'd0);
    check_value("out_req", out_req, 32'd0);
    fork
      send_frames();
      collect_results();
    join
    repeat (32) @(posedge clock);
    if (out_req !== 1'b0)
    begin
      $display("a result was offered after the last expected one");
      other_errors++;
    end
    check_value("captured frame count", captured, nframes);
    // empty queue latency, capture edge to out_req
    if (nframes > 0)
      check_value("first result latency", first_out_cycle - first_cap_cycle, 32'd4);
    if (nframes > QUEUE_DEPTH && stalled_frames == 0)
    begin
      $display("in_ack never stalled, the credit limit was not reached");
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d stalled frames",
             value_errors, other_errors, stalled_frames);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // limit scales with the trace length
  initial
  begin
    wait (trace_loaded);
    repeat (RESET_CYCLES + (nframes + 1) * 64) @(posedge clock);
    other_errors++;
    $display("watchdog expired after %0d cycles, results still missing",
             RESET_CYCLES + (nframes + 1) * 64);
    $display("errors: %0d value mismatches, %0d other failures, %0d stalled frames",
             value_errors, other_errors, stalled_frames);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- rtl/best_1of7.sv
`timescale 1ns/1ns

module best_1of7 #(
  parameter int  KEYS_PER_GROUP = 4,
  parameter int  HIT_THRESH     = 4,
  localparam int LKEY_W         = clct_pkg::lkey_w(KEYS_PER_GROUP),
  localparam int KEY_W          = clct_pkg::GRP_W + LKEY_W
) (
  input  logic                                            clock,
  input  logic                                            rst_n,
  input  logic [clct_pkg::NGROUPS-1:0][LKEY_W-1:0]         grp_local_key,
  input  logic [clct_pkg::NGROUPS-1:0][clct_pkg::PID_W-1:0]  grp_pid,
  input  logic [clct_pkg::NGROUPS-1:0][clct_pkg::NHIT_W-1:0] grp_nhits,
  input  logic [clct_pkg::NGROUPS-1:0]                      frame_busy,
  output logic [KEY_W-1:0]                                 best_key,
  output logic [clct_pkg::PID_W-1:0]                       best_pid,
  output logic [clct_pkg::NHIT_W-1:0]                      best_nhits,
  output logic                                             best_found,
  output logic                                             best_all_busy
);
  import clct_pkg::*;

  // busy mask aligned with the group winners
  logic [NGROUPS-1:0] busy_d1;
  logic [NGROUPS-1:0] busy_d2;
  // winning group and whether any group was free
  logic [GRP_W-1:0]   sel;
  logic               any_free;

  // ----------------------------------------------------------
  // busy delay, match stage then sort stage
  // ----------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      busy_d1 <= '0;
      busy_d2 <= '0;
    end
    else
    begin
      busy_d1 <= frame_busy;
      busy_d2 <= busy_d1;
    end
  end

  // ----------------------------------------------------------
  // best of seven
  // ----------------------------------------------------------
  // busy groups drop out before any compare
  // the first free group seeds the search, later ones need a strictly higher rank
  always_comb
  begin
    sel      = '0;
    any_free = 1'b0;
    for (int g = 0; g < NGROUPS; g++)
    begin
      if (!busy_d2[g])
      begin
        if (!any_free ||
            sort_key(grp_nhits[g], grp_pid[g]) > sort_key(grp_nhits[sel], grp_pid[sel]))
          sel = GRP_W'(g);
        any_free = 1'b1;
      end
    end
  end

  // full key is group index over local key
  always_comb
  begin
    if (any_free)
    begin
      best_key   = {sel, grp_local_key[sel]};
      best_pid   = grp_pid[sel];
      best_nhits = grp_nhits[sel];
    end
    else
    begin
      best_key   = '0;
      best_pid   = '0;
      best_nhits = '0;
    end
  end

  assign best_all_busy = !any_free;
  // below threshold the fields still report, only found stays low
  assign best_found    = any_free && (best_nhits >= NHIT_W'(HIT_THRESH));

  // all-busy only when the captured mask two cycles back was full
  assert property (@(posedge clock) disable iff (!rst_n)
    best_all_busy |-> !best_found && (&$past(frame_busy, 2)));

endmodule

//--- rtl/clct_pattern_finder.sv
`timescale 1ns/1ns

module clct_pattern_finder #(
  parameter int  KEYS_PER_GROUP = 4,
  parameter int  HIT_THRESH     = 4,
  parameter int  QUEUE_DEPTH    = 4,
  localparam int NKEYS          = clct_pkg::NGROUPS * KEYS_PER_GROUP,
  localparam int LKEY_W         = clct_pkg::lkey_w(KEYS_PER_GROUP),
  localparam int KEY_W          = clct_pkg::GRP_W + LKEY_W
) (
  input  logic                                    clock,
  input  logic                                    rst_n,
  input  logic                                    in_req,
  output logic                                    in_ack,
  input  logic [clct_pkg::NLAYERS-1:0][NKEYS-1:0] in_hits,
  input  logic [clct_pkg::NGROUPS-1:0]            in_busy,
  output logic                                    out_req,
  input  logic                                    out_ack,
  output logic [KEY_W-1:0]                        out_key,
  output logic [clct_pkg::PID_W-1:0]              out_pid,
  output logic [clct_pkg::NHIT_W-1:0]             out_nhits,
  output logic                                    out_found,
  output logic                                    out_all_busy
);
  import clct_pkg::*;

  // capture stage
  logic                             frame_valid;
  logic [NLAYERS-1:0][NKEYS-1:0]    frame_hits;
  logic [NGROUPS-1:0]               frame_busy;
  logic                             slot_release;
  // match stage
  logic                             match_valid;
  logic [NKEYS-1:0][PID_W-1:0]      key_pid;
  logic [NKEYS-1:0][NHIT_W-1:0]     key_nhits;
  // group stage with all sorters in lock step
  logic [NGROUPS-1:0]               grp_valid;
  logic [NGROUPS-1:0][LKEY_W-1:0]   grp_local_key;
  logic [NGROUPS-1:0][PID_W-1:0]    grp_pid;
  logic [NGROUPS-1:0][NHIT_W-1:0]   grp_nhits;
  // chamber winner
  logic [KEY_W-1:0]                 best_key;
  logic [PID_W-1:0]                 best_pid;
  logic [NHIT_W-1:0]                best_nhits;
  logic                             best_found;
  logic                             best_all_busy;

  hit_capture #(
    .KEYS_PER_GROUP (KEYS_PER_GROUP),
    .QUEUE_DEPTH    (QUEUE_DEPTH)
  ) hit_capture_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .in_hits      (in_hits),
    .in_busy      (in_busy),
    .slot_release (slot_release),
    .frame_valid  (frame_valid),
    .frame_hits   (frame_hits),
    .frame_busy   (frame_busy)
  );

  pattern_match #(
    .KEYS_PER_GROUP (KEYS_PER_GROUP)
  ) pattern_match_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_hits  (frame_hits),
    .match_valid (match_valid),
    .key_pid     (key_pid),
    .key_nhits   (key_nhits)
  );

  // one sorter per key group
  for (genvar g = 0; g < NGROUPS; g++)
  begin : gen_group
    group_sorter #(
      .KEYS_PER_GROUP (KEYS_PER_GROUP)
    ) group_sorter_i (
      .clock         (clock),
      .rst_n         (rst_n),
      .match_valid   (match_valid),
      .key_pid       (key_pid[g*KEYS_PER_GROUP +: KEYS_PER_GROUP]),
      .key_nhits     (key_nhits[g*KEYS_PER_GROUP +: KEYS_PER_GROUP]),
      .grp_valid     (grp_valid[g]),
      .grp_local_key (grp_local_key[g]),
      .grp_pid       (grp_pid[g]),
      .grp_nhits     (grp_nhits[g])
    );
  end

  best_1of7 #(
    .KEYS_PER_GROUP (KEYS_PER_GROUP),
    .HIT_THRESH     (HIT_THRESH)
  ) best_1of7_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .grp_local_key (grp_local_key),
    .grp_pid       (grp_pid),
    .grp_nhits     (grp_nhits),
    .frame_busy    (frame_busy),
    .best_key      (best_key),
    .best_pid      (best_pid),
    .best_nhits    (best_nhits),
    .best_found    (best_found),
    .best_all_busy (best_all_busy)
  );

  // one queue write per frame once every sorter holds its winner
  result_port #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .KEY_W       (KEY_W)
  ) result_port_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .grp_valid     (&grp_valid),
    .best_key      (best_key),
    .best_pid      (best_pid),
    .best_nhits    (best_nhits),
    .best_found    (best_found),
    .best_all_busy (best_all_busy),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .out_key       (out_key),
    .out_pid       (out_pid),
    .out_nhits     (out_nhits),
    .out_found     (out_found),
    .out_all_busy  (out_all_busy),
    .slot_release  (slot_release)
  );

endmodule

//--- rtl/clct_pkg.sv
package clct_pkg;

  // ----------------------------------------------------------
  // chamber geometry
  // ----------------------------------------------------------

  // six cathode layers, layer 2 is the key layer
  localparam int NLAYERS = 6;
  // key groups across the chamber
  localparam int NGROUPS = 7;
  // pattern shapes tried at every key
  localparam int NPATS   = 5;

  // field widths
  localparam int PID_W  = 3;
  localparam int NHIT_W = 3;
  localparam int SORT_W = 5;
  localparam int GRP_W  = 3;

  // half-strip offset from the key per pattern id and layer, layer 0 first
  // even ids bend left, odd ids bend right, id 4 is straight
  localparam int pattern_shift [NPATS][NLAYERS] = '{
    '{-2, -1, 0, 0,  1,  2},
    '{ 2,  1, 0, 0, -1, -2},
    '{-1, -1, 0, 0,  1,  1},
    '{ 1,  1, 0, 0, -1, -1},
    '{ 0,  0, 0, 0,  0,  0}
  };

  // width of a local key inside a group of n keys
  function automatic int lkey_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // rank value, pid lsb is only the bend direction so it is dropped
  function automatic logic [SORT_W-1:0] sort_key(input logic [NHIT_W-1:0] nhits,
                                                 input logic [PID_W-1:0]  pid);
    return {nhits, pid[PID_W-1:1]};
  endfunction

endpackage

//--- rtl/group_sorter.sv
`timescale 1ns/1ns

module group_sorter #(
  parameter int  KEYS_PER_GROUP = 4,
  localparam int LKEY_W         = clct_pkg::lkey_w(KEYS_PER_GROUP)
) (
  input  logic                                           clock,
  input  logic                                           rst_n,
  input  logic                                           match_valid,
  input  logic [KEYS_PER_GROUP-1:0][clct_pkg::PID_W-1:0]  key_pid,
  input  logic [KEYS_PER_GROUP-1:0][clct_pkg::NHIT_W-1:0] key_nhits,
  output logic                                           grp_valid,
  output logic [LKEY_W-1:0]                              grp_local_key,
  output logic [clct_pkg::PID_W-1:0]                     grp_pid,
  output logic [clct_pkg::NHIT_W-1:0]                    grp_nhits
);
  import clct_pkg::*;

  logic [LKEY_W-1:0] sel;

  // linear scan from key 0
  // strict compare keeps the lowest key on a tie
  always_comb
  begin
    sel = '0;
    for (int k = 1; k < KEYS_PER_GROUP; k++)
    begin
      if (sort_key(key_nhits[k], key_pid[k]) > sort_key(key_nhits[sel], key_pid[sel]))
        sel = LKEY_W'(k);
    end
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      grp_valid <= 1'b0;
    else
      grp_valid <= match_valid;
  end

  // group winner
  always_ff @(posedge clock)
  begin
    if (match_valid)
    begin
      grp_local_key <= sel;
      grp_pid       <= key_pid[sel];
      grp_nhits     <= key_nhits[sel];
    end
  end

endmodule

//--- rtl/hit_capture.sv
`timescale 1ns/1ns

module hit_capture #(
  parameter int  KEYS_PER_GROUP = 4,
  parameter int  QUEUE_DEPTH    = 4,
  localparam int NKEYS          = clct_pkg::NGROUPS * KEYS_PER_GROUP
) (
  input  logic                                       clock,
  input  logic                                       rst_n,
  input  logic                                       in_req,
  output logic                                       in_ack,
  input  logic [clct_pkg::NLAYERS-1:0][NKEYS-1:0]    in_hits,
  input  logic [clct_pkg::NGROUPS-1:0]               in_busy,
  input  logic                                       slot_release,
  output logic                                       frame_valid,
  output logic [clct_pkg::NLAYERS-1:0][NKEYS-1:0]    frame_hits,
  output logic [clct_pkg::NGROUPS-1:0]               frame_busy
);

  localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

  // free result queue slots not yet claimed by a frame
  logic [CRED_W-1:0] credits;
  logic              take;

  // accept only a fresh request, i.e. ack low, and only with a slot in hand
  assign take = in_req && !in_ack && (credits != '0);

  // ----------------------------------------------------------
  // four-phase state and credits
  // ----------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      in_ack      <= 1'b0;
      frame_valid <= 1'b0;
      credits     <= CRED_W'(QUEUE_DEPTH);
    end
    else
    begin
      frame_valid <= take;
      // ack follows the source down once req is released
      if (take)
        in_ack <= 1'b1;
      else if (!in_req)
        in_ack <= 1'b0;
      // one slot spent per capture, one back per queue pop
      credits <= credits - CRED_W'(take) + CRED_W'(slot_release);
    end
  end

  // frame latch, held until the next capture
  always_ff @(posedge clock)
  begin
    if (take)
    begin
      frame_hits <= in_hits;
      frame_busy <= in_busy;
    end
  end

  // back-pressure holds when the queue is fully booked
  assert property (@(posedge clock) disable iff (!rst_n)
    $rose(in_ack) |-> $past(credits) != '0);

endmodule

//--- rtl/pattern_match.sv
`timescale 1ns/1ns

module pattern_match #(
  parameter int  KEYS_PER_GROUP = 4,
  localparam int NKEYS          = clct_pkg::NGROUPS * KEYS_PER_GROUP
) (
  input  logic                                       clock,
  input  logic                                       rst_n,
  input  logic                                       frame_valid,
  input  logic [clct_pkg::NLAYERS-1:0][NKEYS-1:0]    frame_hits,
  output logic                                       match_valid,
  output logic [NKEYS-1:0][clct_pkg::PID_W-1:0]      key_pid,
  output logic [NKEYS-1:0][clct_pkg::NHIT_W-1:0]     key_nhits
);
  import clct_pkg::*;

  // best pattern per key, before the register
  logic [NKEYS-1:0][PID_W-1:0]  pid_c;
  logic [NKEYS-1:0][NHIT_W-1:0] nhits_c;

  // ----------------------------------------------------------
  // layer count per key and pattern
  // ----------------------------------------------------------
  always_comb
  begin
    int                idx;
    logic [NHIT_W-1:0] cnt;
    for (int k = 0; k < NKEYS; k++)
    begin
      pid_c[k]   = '0;
      nhits_c[k] = '0;
      for (int p = 0; p < NPATS; p++)
      begin
        cnt = '0;
        for (int l = 0; l < NLAYERS; l++)
        begin
          idx = k + pattern_shift[p][l];
          // half-strips past either chamber edge never hit
          if (idx >= 0 && idx < NKEYS)
            cnt = cnt + NHIT_W'(frame_hits[l][idx]);
        end
        // ids are scanned upward, so an equal rank lets the higher id take over
        if (sort_key(cnt, PID_W'(p)) >= sort_key(nhits_c[k], pid_c[k]))
        begin
          pid_c[k]   = PID_W'(p);
          nhits_c[k] = cnt;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // output register
  // ----------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (!rst_n)
      match_valid <= 1'b0;
    else
      match_valid <= frame_valid;
  end

  // per-key results load only on a new frame
  always_ff @(posedge clock)
  begin
    if (frame_valid)
    begin
      key_pid   <= pid_c;
      key_nhits <= nhits_c;
    end
  end

endmodule

//--- rtl/result_port.sv
`timescale 1ns/1ns

module result_port #(
  parameter int QUEUE_DEPTH = 4,
  parameter int KEY_W       = 5
) (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          grp_valid,
  input  logic [KEY_W-1:0]              best_key,
  input  logic [clct_pkg::PID_W-1:0]    best_pid,
  input  logic [clct_pkg::NHIT_W-1:0]   best_nhits,
  input  logic                          best_found,
  input  logic                          best_all_busy,
  output logic                          out_req,
  input  logic                          out_ack,
  output logic [KEY_W-1:0]              out_key,
  output logic [clct_pkg::PID_W-1:0]    out_pid,
  output logic [clct_pkg::NHIT_W-1:0]   out_nhits,
  output logic                          out_found,
  output logic                          out_all_busy,
  output logic                          slot_release
);
  import clct_pkg::*;

  localparam int ENTRY_W = KEY_W + PID_W + NHIT_W + 2;
  localparam int ADDR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);

  // result queue
  logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [ENTRY_W-1:0] head;
  logic               pop;

  // pointer wrap for depths that are not a power of two
  function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
    return (ptr == ADDR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // sink ack seen while req is up
  assign pop  = out_req && out_ack;
  assign head = mem[rd_ptr];
  assign {out_key, out_pid, out_nhits, out_found, out_all_busy} = head;

  always_ff @(posedge clock)
  begin
    if (grp_valid)
      mem[wr_ptr] <= {best_key, best_pid, best_nhits, best_found, best_all_busy};
  end

  // ----------------------------------------------------------
  // pointers and output four-phase
  // ----------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      out_req      <= 1'b0;
      slot_release <= 1'b0;
    end
    else
    begin
      slot_release <= pop;
      if (grp_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(grp_valid) - CNT_W'(pop);
      // next req waits for the sink to release ack
      if (pop)
        out_req <= 1'b0;
      else if (!out_req && !out_ack && (count != '0))
        out_req <= 1'b1;
    end
  end

  // head data held for the whole request
  assert property (@(posedge clock) disable iff (!rst_n)
    out_req && $past(out_req) |-> $stable(head));

  // credits upstream keep the queue from overfilling
  assert property (@(posedge clock) disable iff (!rst_n)
    grp_valid |-> (count < CNT_W'(QUEUE_DEPTH)) || pop);

endmodule

//--- sources.f
rtl/clct_pkg.sv
rtl/hit_capture.sv
rtl/pattern_match.sv
rtl/group_sorter.sv
rtl/best_1of7.sv
rtl/result_port.sv
rtl/clct_pattern_finder.sv
bench/tb_clct_pattern_finder.sv
